// File: all.f
+incdir+tests
design/vgaPkg.sv
design/syncAxisCounter.sv
design/videoTimer.sv
design/tileMemory.sv
design/pixelPipeline.sv
design/vgaSubsystem.sv
tests/vgaTb.sv

// File: design/pixelPipeline.sv
`timescale 1ns/1ps

module pixelPipeline (
	input  logic PIXELCLK,
	input  logic nRESET,
	input  vgaPkg::videoTiming_s timing,
	input  logic [vgaPkg::colorIndexW-1:0] colorIndex,
	output logic VGA_HSYNC,
	output logic VGA_VSYNC,
	output logic [vgaPkg::rgbW-1:0] VGA_RGB
);

	logic hsyncD1;
	logic vsyncD1;
	logic activeD1;

	// stage one, in step with the tile read.
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			hsyncD1 <= 1'b0;
			vsyncD1 <= 1'b0;
			activeD1 <= 1'b0;
		end else begin
			hsyncD1 <= timing.hsync;
			vsyncD1 <= timing.vsync;
			activeD1 <= timing.active;
		end
	end

	// stage two, palette lookup and blanking.
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			VGA_HSYNC <= 1'b0;
			VGA_VSYNC <= 1'b0;
			VGA_RGB <= '0;
		end else begin
			VGA_HSYNC <= hsyncD1;
			VGA_VSYNC <= vsyncD1;
			if (activeD1) begin
				VGA_RGB <= vgaPkg::palette[colorIndex];
			end else begin
				VGA_RGB <= '0; // black in blanking.
			end
		end
	end

	// active flag delayed to line up with the color.
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		!$past(timing.active, 2) |-> VGA_RGB == '0)
		else $error("pixelPipeline: color driven during blanking.");

	// syncs trail the timer by the same two cycles as the color.
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		##2 (VGA_HSYNC == $past(timing.hsync, 2)) && (VGA_VSYNC == $past(timing.vsync, 2)))
		else $error("pixelPipeline: sync outputs out of step.");

endmodule

// File: design/syncAxisCounter.sv
`timescale 1ns/1ps

module syncAxisCounter #(
	parameter int countInit = 655,
	parameter int pulseInit = 95,
	parameter int backPorch = 47,
	parameter int activeLength = 640
) (
	input  logic PIXELCLK,
	input  logic nRESET,
	input  logic advance,
	output logic sync,
	output logic active,
	output logic [9:0] position,
	output vgaPkg::syncPhase_e phase,
	output logic endOfPeriod
);

	logic [9:0] count; // advances left in the current phase.
	logic countZero;

	assign countZero = (count == '0);

	// display+front porch, then pulse, then back porch.
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			phase <= vgaPkg::displayPhase;
			count <= 10'(countInit);
			position <= '0;
		end else if (advance) begin
			unique case (phase)
				vgaPkg::displayPhase: begin
					position <= position + 10'd1;
					if (countZero) begin
						phase <= vgaPkg::pulsePhase;
						count <= 10'(pulseInit);
					end else begin
						count <= count - 10'd1;
					end
				end
				vgaPkg::pulsePhase: begin
					if (countZero) begin
						phase <= vgaPkg::porchPhase;
						count <= 10'(backPorch);
					end else begin
						count <= count - 10'd1;
					end
				end
				vgaPkg::porchPhase: begin
					if (countZero) begin
						phase <= vgaPkg::displayPhase;
						count <= 10'(countInit);
						position <= '0; // wrap to start of period.
					end else begin
						count <= count - 10'd1;
					end
				end
				default: begin
					phase <= vgaPkg::displayPhase;
					count <= 10'(countInit);
					position <= '0;
				end
			endcase
		end
	end

	assign sync = (phase == vgaPkg::pulsePhase); // high during pulse.

	// front porch is the tail of the display phase.
	assign active = (phase == vgaPkg::displayPhase) && (position < 10'(activeLength));

	assign endOfPeriod = advance && (phase == vgaPkg::porchPhase) && countZero;

	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		phase inside {vgaPkg::displayPhase, vgaPkg::pulsePhase, vgaPkg::porchPhase})
		else $error("syncAxisCounter: illegal phase %0d.", phase);

endmodule

// File: design/tileMemory.sv
`timescale 1ns/1ps

module tileMemory (
	input  logic PIXELCLK,
	input  logic nRESET,
	input  vgaPkg::tileWrite_s tileWrite,
	input  logic tileWriteValid,
	input  vgaPkg::videoTiming_s timing,
	output logic tileWriteReady,
	output logic [vgaPkg::colorIndexW-1:0] colorIndex
);

	localparam int tileCols = 40;
	localparam int tileRows = 30;
	localparam int depth = tileCols * tileRows;
	localparam int addrW = $clog2(depth);

	logic [vgaPkg::colorIndexW-1:0] mem [depth];
	logic [addrW-1:0] sweepAddr;
	logic sweepDone;
	logic [addrW-1:0] readAddr;
	logic [addrW-1:0] writeAddr;
	logic writeFire;

	// tiles are 16x16, row-major.
	assign readAddr = addrW'(timing.lineY[4 +: vgaPkg::tileRowsW]) * addrW'(tileCols)
		+ addrW'(timing.pixelX[4 +: vgaPkg::tileColsW]);
	assign writeAddr = addrW'(tileWrite.tileRow) * addrW'(tileCols)
		+ addrW'(tileWrite.tileCol);

	// single port, so writes wait for blanking.
	assign tileWriteReady = sweepDone & ~timing.active;
	assign writeFire = tileWriteValid & tileWriteReady;

	// clear sweep after reset, one entry per cycle.
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			sweepAddr <= '0;
			sweepDone <= 1'b0;
		end else if (!sweepDone) begin
			sweepAddr <= sweepAddr + 1'b1;
			sweepDone <= (sweepAddr == addrW'(depth - 1));
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!sweepDone) begin
			mem[sweepAddr] <= '0;
		end else if (writeFire) begin
			mem[writeAddr] <= tileWrite.colorIndex;
		end
	end

	// table reads as all zero until the sweep is through.
	always_ff @(posedge PIXELCLK) begin
		if (!sweepDone) begin
			colorIndex <= '0;
		end else if (timing.active) begin
			colorIndex <= mem[readAddr];
		end
	end

	// visible window rebuilt from phases and positions.
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		writeFire |-> !((timing.hPhase == vgaPkg::displayPhase)
			&& (timing.vPhase == vgaPkg::displayPhase)
			&& (timing.pixelX < 10'(tileCols * 16))
			&& (timing.lineY < 10'(tileRows * 16))))
		else $error("tileMemory: write accepted during active video.");

	// host must hold a stalled request.
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		tileWriteValid && !tileWriteReady |=> tileWriteValid && $stable(tileWrite))
		else $error("tileMemory: write request dropped or changed while stalled.");

endmodule

// File: design/vgaPkg.sv
package vgaPkg;

	localparam int tileColsW = 6;
	localparam int tileRowsW = 5;
	localparam int colorIndexW = 4;
	localparam int rgbW = 12; // 4 bits per channel, r in the top nibble.

	typedef enum logic [1:0] {
		displayPhase,
		pulsePhase,
		porchPhase
	} syncPhase_e;

	// host write payload.
	typedef struct packed {
		logic [tileColsW-1:0] tileCol;
		logic [tileRowsW-1:0] tileRow;
		logic [colorIndexW-1:0] colorIndex;
	} tileWrite_s;

	// timer output, one per pixel clock.
	typedef struct packed {
		logic [9:0] pixelX;
		logic [9:0] lineY;
		logic active;
		logic hsync;
		logic vsync;
		syncPhase_e hPhase;
		syncPhase_e vPhase;
	} videoTiming_s;

	// fixed color table, 0 is black and 15 is white.
	localparam logic [rgbW-1:0] palette [0:15] = '{
		12'h000,
		12'h00A,
		12'h0A0,
		12'h0AA,
		12'hA00,
		12'hA0A,
		12'hA50,
		12'hAAA,
		12'h555,
		12'h55F,
		12'h5F5,
		12'h5FF,
		12'hF55,
		12'hF5F,
		12'hFF5,
		12'hFFF
	};

endpackage

// File: design/vgaSubsystem.sv
`timescale 1ns/1ps

module vgaSubsystem #(
	parameter int hCountInit = 655,
	parameter int hPulseInit = 95,
	parameter int hBackPorch = 47,
	parameter int hActiveLength = 640,
	parameter int vCountInit = 490,
	parameter int vPulseInit = 1,
	parameter int vBackPorch = 30,
	parameter int vActiveLength = 480
) (
	input  logic PIXELCLK,
	input  logic nRESET,
	input  vgaPkg::tileWrite_s tileWrite,
	input  logic tileWriteValid,
	output logic tileWriteReady,
	output logic VGA_HSYNC,
	output logic VGA_VSYNC,
	output logic [vgaPkg::rgbW-1:0] VGA_RGB
);

	vgaPkg::videoTiming_s timing;
	logic [vgaPkg::colorIndexW-1:0] colorIndex; // one cycle behind timing.

	videoTimer #(
		.hCountInit(hCountInit),
		.hPulseInit(hPulseInit),
		.hBackPorch(hBackPorch),
		.hActiveLength(hActiveLength),
		.vCountInit(vCountInit),
		.vPulseInit(vPulseInit),
		.vBackPorch(vBackPorch),
		.vActiveLength(vActiveLength)
	) timer (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.timing(timing)
	);

	tileMemory tiles (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.tileWrite(tileWrite),
		.tileWriteValid(tileWriteValid),
		.timing(timing),
		.tileWriteReady(tileWriteReady),
		.colorIndex(colorIndex)
	);

	pixelPipeline pipeline (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.timing(timing),
		.colorIndex(colorIndex),
		.VGA_HSYNC(VGA_HSYNC),
		.VGA_VSYNC(VGA_VSYNC),
		.VGA_RGB(VGA_RGB)
	);

endmodule

// File: design/videoTimer.sv
`timescale 1ns/1ps

module videoTimer #(
	parameter int hCountInit = 655,
	parameter int hPulseInit = 95,
	parameter int hBackPorch = 47,
	parameter int hActiveLength = 640,
	parameter int vCountInit = 490,
	parameter int vPulseInit = 1,
	parameter int vBackPorch = 30,
	parameter int vActiveLength = 480
) (
	input  logic PIXELCLK,
	input  logic nRESET,
	output vgaPkg::videoTiming_s timing
);

	logic hSync;
	logic hActive;
	logic hEnd; // last cycle of the line.
	logic [9:0] hPos;
	vgaPkg::syncPhase_e hPhase;
	logic vSync;
	logic vActive;
	logic [9:0] vPos;
	vgaPkg::syncPhase_e vPhase;

	syncAxisCounter #(
		.countInit(hCountInit),
		.pulseInit(hPulseInit),
		.backPorch(hBackPorch),
		.activeLength(hActiveLength)
	) horizontal (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.advance(1'b1),
		.sync(hSync),
		.active(hActive),
		.position(hPos),
		.phase(hPhase),
		.endOfPeriod(hEnd)
	);

	// vertical axis steps once per line.
	syncAxisCounter #(
		.countInit(vCountInit),
		.pulseInit(vPulseInit),
		.backPorch(vBackPorch),
		.activeLength(vActiveLength)
	) vertical (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.advance(hEnd),
		.sync(vSync),
		.active(vActive),
		.position(vPos),
		.phase(vPhase),
		.endOfPeriod()
	);

	assign timing = '{
		pixelX: hPos,
		lineY: vPos,
		active: hActive & vActive,
		hsync: hSync,
		vsync: vSync,
		hPhase: hPhase,
		vPhase: vPhase
	};

	// vsync edges land on line boundaries.
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		$changed(timing.vsync) |-> $past(hEnd))
		else $error("videoTimer: vsync moved mid-line.");

endmodule

// File: tests/vgaTests.svh
task automatic testHorizontalTiming();
	int n;
	int high;
	int low;
	waitSyncEdge(1'b0, 1'b1, lineLen + 10, n);
	waitSyncEdge(1'b0, 1'b0, lineLen, high);
	waitSyncEdge(1'b0, 1'b1, lineLen, low);
	checkEqual("testHorizontalTiming pulse", hPulse, high);
	checkEqual("testHorizontalTiming period", lineLen, high + low);
endtask

// vsync edges sit at line starts, so the next hsync rise is one display phase away.
task automatic testVerticalTiming();
	int n;
	int a;
	int b;
	int c;
	int d;
	waitSyncEdge(1'b1, 1'b1, frameCycles + lineLen, n);
	waitSyncEdge(1'b0, 1'b1, lineLen, a);
	checkEqual("testVerticalTiming rise to hsync", hDisplay, a);
	waitSyncEdge(1'b1, 1'b0, 2 * lineLen, b);
	checkEqual("testVerticalTiming pulse", vPulseLines * lineLen, a + b);
	waitSyncEdge(1'b0, 1'b1, lineLen, c);
	checkEqual("testVerticalTiming fall to hsync", hDisplay, c);
	waitSyncEdge(1'b1, 1'b1, frameCycles, d);
	checkEqual("testVerticalTiming period", frameCycles, a + b + c + d);
endtask

task automatic testBlanking();
	int stall;
	scanFrame("testBlanking cleared");
	for (int r = 0; r < 30; r++) begin
		for (int c = 0; c < 40; c++) begin
			writeTile(c, r, 15, stall); // white makes the window visible.
		end
	end
	scanFrame("testBlanking window");
endtask

task automatic testTileWrite();
	int col;
	int row;
	int idx;
	int stall;
	for (int i = 0; i < 6; i++) begin
		col = $urandom % 40;
		row = $urandom % 30;
		idx = $urandom % 15; // differs from the white fill.
		writeTile(col, row, idx, stall);
	end
	scanFrame("testTileWrite");
endtask

task automatic testBackPressure();
	int n;
	int col;
	int idx;
	int stall;
	col = $urandom % 40;
	idx = (tileModel[0][col] + 1 + $urandom % 15) % 16;
	waitSyncEdge(1'b1, 1'b0, frameCycles + lineLen, n);
	repeat (firstLine * lineLen - 2) @(negedge PIXELCLK); // timer enters first active line.
	writeTile(col, 0, idx, stall);
	checkEqual("testBackPressure stall", activeW, stall);
	scanFrame("testBackPressure");
endtask

// File: tests/vgaTb.sv
`timescale 1ns/1ps

module vgaTb;

	localparam int lineLen = 800;
	localparam int frameLines = 524;
	localparam int frameCycles = lineLen * frameLines;
	localparam int hPulse = 96;
	localparam int hDisplay = 656; // display plus front porch.
	localparam int vPulseLines = 2;
	localparam int activeW = 640;
	localparam int activeH = 480;
	localparam int firstLine = 31; // lines from vsync fall to first active line.
	localparam int tileSize = 16;
	localparam int readyLimit = 1000;

	logic PIXELCLK;
	logic nRESET;
	vgaPkg::tileWrite_s tileWrite;
	logic tileWriteValid;
	logic tileWriteReady;
	logic VGA_HSYNC;
	logic VGA_VSYNC;
	logic [vgaPkg::rgbW-1:0] VGA_RGB;

	logic [vgaPkg::colorIndexW-1:0] tileModel [0:29][0:39]; // expected tile contents.
	int seed;

	vgaSubsystem DUT (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.tileWrite(tileWrite),
		.tileWriteValid(tileWriteValid),
		.tileWriteReady(tileWriteReady),
		.VGA_HSYNC(VGA_HSYNC),
		.VGA_VSYNC(VGA_VSYNC),
		.VGA_RGB(VGA_RGB)
	);

	initial begin
		PIXELCLK = 1'b0;
		forever #2 PIXELCLK = ~PIXELCLK;
	end

	task automatic checkEqual(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("error: %s expected %0h actual %0h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "stopped at first mismatch.");
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("timeout: %s", what);
		$display("=== FAIL ===");
		$fatal(1, "stopped on timeout.");
	endtask

	function automatic bit syncLevel(input bit vertical);
		return vertical ? VGA_VSYNC : VGA_HSYNC;
	endfunction

	// returns on the first sample where the sync has just reached level.
	task automatic waitSyncEdge(input bit vertical, input bit level, input int limit,
		output int cycles);
		bit prev;
		prev = syncLevel(vertical);
		cycles = 0;
		while (cycles < limit) begin
			@(negedge PIXELCLK);
			cycles++;
			if (syncLevel(vertical) == level && prev != level) begin
				return;
			end
			prev = syncLevel(vertical);
		end
		reportTimeout($sformatf("%s never went %s", vertical ? "VGA_VSYNC" : "VGA_HSYNC",
			level ? "high" : "low"));
	endtask

	task automatic writeTile(input int col, input int row, input int idx, output int stall);
		stall = 0;
		tileWrite.tileCol = col[vgaPkg::tileColsW-1:0];
		tileWrite.tileRow = row[vgaPkg::tileRowsW-1:0];
		tileWrite.colorIndex = idx[vgaPkg::colorIndexW-1:0];
		tileWriteValid = 1'b1;
		while (!tileWriteReady) begin
			stall++;
			if (stall > readyLimit) begin
				reportTimeout("tileWriteReady never rose for a pending write");
			end
			@(negedge PIXELCLK);
		end
		@(negedge PIXELCLK); // handshake done on the edge just passed.
		tileWriteValid = 1'b0;
		tileModel[row][col] = idx[vgaPkg::colorIndexW-1:0];
	endtask

	// one full frame from vsync fall, every cycle against the tile model.
	task automatic scanFrame(input string name);
		int n;
		int k;
		int line;
		int x;
		int expected;
		waitSyncEdge(1'b1, 1'b0, frameCycles + lineLen, n);
		for (k = 0; k < frameCycles; k++) begin
			line = k / lineLen;
			x = k % lineLen; // line start is 48 cycles after hsync fall.
			if (line >= firstLine && line < firstLine + activeH && x < activeW) begin
				expected = vgaPkg::palette[tileModel[(line - firstLine) / tileSize][x / tileSize]];
			end else begin
				expected = 0;
			end
			if (expected != int'(VGA_RGB)) begin
				checkEqual($sformatf("%s line %0d cycle %0d", name, line, x), expected, VGA_RGB);
			end
			@(negedge PIXELCLK);
		end
	endtask

	`include "vgaTests.svh"

	initial begin
		seed = 66368;
		void'($urandom(seed));
		nRESET = 1'b0;
		tileWrite = '0;
		tileWriteValid = 1'b0;
		for (int r = 0; r < 30; r++) begin
			for (int c = 0; c < 40; c++) begin
				tileModel[r][c] = '0;
			end
		end
		repeat (8) @(negedge PIXELCLK);
		checkEqual("reset hsync", 0, VGA_HSYNC);
		checkEqual("reset vsync", 0, VGA_VSYNC);
		checkEqual("reset rgb", 0, VGA_RGB);
		checkEqual("reset ready", 0, tileWriteReady);
		nRESET = 1'b1;
		testHorizontalTiming();
		testVerticalTiming();
		testBlanking();
		testTileWrite();
		testBackPressure();
		$display("=== PASS ===");
		$finish;
	end

endmodule
